// File: compile.f
hdl/udp_oe_csr_pkg.sv
hdl/chan_addr_decode.sv
hdl/shared_csr_regs.sv
hdl/chan_ctrl_regs.sv
hdl/csr_read_resp.sv
hdl/udp_oe_csr_top.sv
dv/udp_oe_csr_asserts.sv
dv/tb_udp_oe_csr.sv

// File: dv/csr_stim.txt
# op byte_addr value: W write, R read and expect value, S set channel status
# byte_addr is decimal (channel number for S), value is 64-bit hex, tx status high for S
R 0 10100100000000AB
R 8 9A1F2C6D4B07E315
R 16 5E84B0C271D94F36
R 24 0000000000000050
R 32 0000050000000000
R 48 0000000000000004
R 56 0000000000000000
R 112 0000000000000400
W 40 DEADBEEFCAFEF00D
W 56 FFFFFFFFFFFFFFFF
W 64 FFFFFFFFFFFFFFFF
W 72 FFFFFFFFFFFFFFFF
W 80 FFFFFFFFFFFFFFFF
W 88 0123456789ABCDEF
W 96 11223344C0A80001
W 104 FFFFFFFFFFFFABCD
W 112 FFFFFFFFFFFF05DC
W 120 000000000000BEEF
R 40 DEADBEEFCAFEF00D
R 56 0000FFFFFFFFFFFF
R 64 00000000FFFFFFFF
R 72 000000000000FFFF
R 80 00000000FFFFFFFF
R 88 0000456789ABCDEF
R 96 00000000C0A80001
R 104 000000000000ABCD
R 112 00000000000005DC
R 120 000000000000BEEF
W 264 0000000000000003
R 264 0000000000000003
W 328 0000000000000002
R 328 0000000000000002
W 392 0000000000000001
R 392 0000000000000001
W 456 0000000000000002
R 456 0000000000000002
W 408 00000000A5A5A5A5
R 280 00000000A5A5A5A5
S 1 1111111122222222
S 3 AAAAAAAA55555555
R 256 0000000000000010
R 320 0000000000000110
R 384 0000000000000210
R 448 0000000000000310
R 336 1111111122222222
R 464 AAAAAAAA55555555
R 272 0000000000000000
R 288 0000000000000000
R 504 0000000000000000
R 128 0BAD0BAD0BAD0BAD
R 512 0BAD0BAD0BAD0BAD
R 200 0BAD0BAD0BAD0BAD

// File: dv/tb_udp_oe_csr.sv
//////////////////////////////////////////////////
// Testbench for the UDP offload CSR block, driven
// from a stimulus file with queued read checks
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_udp_oe_csr
    import udp_oe_csr_pkg::*;
();

    localparam int    NUM_CHAN   = 4;
    localparam int    CHAN_IDX_W = chan_idx_width(NUM_CHAN);
    localparam string STIM_FILE  = "dv/csr_stim.txt";

    logic                uoe_csr_avmm;
    logic                rst_local;
    logic [12:0]         address;
    logic                read;
    logic                write;
    csr_word_t           writedata;
    csr_word_t           readdata;
    logic                readdatavalid;
    chan_sts_t           tx_status [NUM_CHAN];
    chan_sts_t           rx_status [NUM_CHAN];
    logic [NUM_CHAN-1:0] tx_rst;
    logic [NUM_CHAN-1:0] rx_rst;
    csr_word_t           misc_ctrl;
    mac_adr_t            fpga_mac_adr;
    mac_adr_t            host_mac_adr;
    ip_adr_t             fpga_ip_adr;
    ip_adr_t             host_ip_adr;
    ip_adr_t             fpga_netmask;
    udp_port_t           fpga_udp_port;
    udp_port_t           host_udp_port;
    udp_port_t           payload_per_packet;
    udp_port_t           checksum_ip;

    logic [7:0]          op_q [$];
    int                  addr_q [$];
    csr_word_t           val_q [$];
    csr_word_t           want_q [$];    // Expected read data in issue order
    logic [NUM_CHAN-1:0] want_tx_rst;
    logic [NUM_CHAN-1:0] want_rx_rst;
    csr_word_t           want_misc;
    csr_word_t           want_word [1024];  // Last value written to each word address
    int                  mismatch_count;
    int                  other_count;
    int                  cycle_count;
    int                  cycle_limit;

    udp_oe_csr_top #(.NUM_CHAN(NUM_CHAN)) dut (.*);

    initial begin
        uoe_csr_avmm = 1'b0;
        forever #5 uoe_csr_avmm = ~uoe_csr_avmm;
    end

    always @(posedge uoe_csr_avmm) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d reads outstanding",
                     cycle_count, want_q.size());
            $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Lines starting with # are comments
    task automatic load_stim();
        int         fd;
        int         rc;
        string      line;
        logic [7:0] op;
        int         addr;
        csr_word_t  val;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %s", STIM_FILE);
            other_count++;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%c %d %h", op, addr, val);
                if (rc == 3) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    val_q.push_back(val);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_outputs();
        csr_word_t want;
        if (readdatavalid) begin
            assert (want_q.size() > 0) else begin
                $display("Read data strobe at %0t with no read outstanding", $time);
                other_count++;
            end
            if (want_q.size() > 0) begin
                want = want_q.pop_front();
                assert (readdata === want) else begin
                    $display("mismatch at %0t: readdata %h, expected %h",
                             $time, readdata, want);
                    mismatch_count++;
                end
            end
        end
        assert (tx_rst === want_tx_rst && rx_rst === want_rx_rst) else begin
            $display("mismatch at %0t: tx_rst %b rx_rst %b, expected %b %b",
                     $time, tx_rst, rx_rst, want_tx_rst, want_rx_rst);
            mismatch_count++;
        end
        assert (misc_ctrl === want_misc) else begin
            $display("mismatch at %0t: misc_ctrl %h, expected %h",
                     $time, misc_ctrl, want_misc);
            mismatch_count++;
        end
        // Each output holds the low bits of the last write to its word
        assert (fpga_mac_adr       === want_word[FPGA_MAC_ADDR][47:0] &&
                host_mac_adr       === want_word[HOST_MAC_ADDR][47:0] &&
                fpga_ip_adr        === want_word[FPGA_IP_ADDR][31:0] &&
                host_ip_adr        === want_word[HOST_IP_ADDR][31:0] &&
                fpga_netmask       === want_word[FPGA_NETMASK_ADDR][31:0] &&
                fpga_udp_port      === want_word[FPGA_UDP_PORT_ADDR][15:0] &&
                host_udp_port      === want_word[HOST_UDP_PORT_ADDR][15:0] &&
                payload_per_packet === want_word[PAYLOAD_PER_PACKET_ADDR][15:0] &&
                checksum_ip        === want_word[CHECKSUM_IP_ADDR][15:0]) else begin
            $display("mismatch at %0t: network settings differ from last writes", $time);
            mismatch_count++;
        end
    endtask

    task automatic run_op(input logic [7:0] op, input int addr, input csr_word_t val);
        int                    chan_ofs;
        logic [CHAN_IDX_W-1:0] ch;
        read      = 1'b0;
        write     = 1'b0;
        address   = 13'(addr);
        writedata = val;
        chan_ofs  = addr / 8 - int'(CHAN_BASE_ADDR);  // Word offset into channel window
        case (op)
            "W": begin
                write = 1'b1;
                want_word[word_addr_t'(addr / 8)] = val;
                if (chan_ofs >= 0 && chan_ofs < NUM_CHAN * CSR_ADDR_PER_CHANNEL) begin
                    ch = CHAN_IDX_W'(chan_ofs / CSR_ADDR_PER_CHANNEL);
                    if (chan_ofs % CSR_ADDR_PER_CHANNEL == int'(CHAN_RESET_OFS)) begin
                        want_tx_rst[ch] = val[1];
                        want_rx_rst[ch] = val[0];
                    end
                    if (chan_ofs % CSR_ADDR_PER_CHANNEL == int'(CHAN_MISC_CTRL_OFS)) begin
                        want_misc = val;  // Shared by all channels
                    end
                end
            end
            "R": begin
                read = 1'b1;
                want_q.push_back(val);
            end
            "S": begin
                ch = CHAN_IDX_W'(addr);     // Address column holds the channel
                tx_status[ch] = val[63:32];
                rx_status[ch] = val[31:0];
            end
            default: begin
                $display("Unknown stimulus operation '%c'", op);
                other_count++;
            end
        endcase
    endtask

    initial begin
        rst_local      = 1'b1;
        address        = '0;
        read           = 1'b0;
        write          = 1'b0;
        writedata      = '0;
        want_tx_rst    = '0;
        want_rx_rst    = '0;
        want_misc      = '0;
        mismatch_count = 0;
        other_count    = 0;
        cycle_count    = 0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            tx_status[c] = '0;
            rx_status[c] = '0;
        end
        foreach (want_word[a]) begin
            want_word[a] = '0;
        end
        want_word[PAYLOAD_PER_PACKET_ADDR] = 64'd1024;  // Payload size after reset
        load_stim();
        cycle_limit = 4 * op_q.size() + 20;

        repeat (2) @(posedge uoe_csr_avmm);
        @(negedge uoe_csr_avmm);
        rst_local = 1'b0;

        foreach (op_q[i]) begin
            @(negedge uoe_csr_avmm);
            check_outputs();
            run_op(op_q[i], addr_q[i], val_q[i]);
        end
        @(negedge uoe_csr_avmm);
        check_outputs();
        read  = 1'b0;
        write = 1'b0;
        while (want_q.size() > 0) begin
            @(negedge uoe_csr_avmm);
            check_outputs();
        end
        repeat (2) begin
            @(negedge uoe_csr_avmm);
            check_outputs();   // No stray strobes once idle
        end

        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_udp_oe_csr

`default_nettype wire

// File: dv/udp_oe_csr_asserts.sv
//////////////////////////////////////////////////
// Bound checks on the read strobe and the channel
// reset outputs
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module udp_oe_csr_asserts #(
    parameter int NUM_CHAN = 4
) (
    input logic                uoe_csr_avmm,
    input logic                rst_local,
    input logic                read,
    input logic                readdatavalid,
    input logic [NUM_CHAN-1:0] tx_rst,
    input logic [NUM_CHAN-1:0] rx_rst
);

    // One strobe on the edge after each accepted read
    a_valid_after_read: assert property (
        @(posedge uoe_csr_avmm) disable iff (rst_local) read |=> readdatavalid
    ) else $error("readdatavalid did not follow a read");

    a_no_stray_valid: assert property (
        @(posedge uoe_csr_avmm) disable iff (rst_local) !read |=> !readdatavalid
    ) else $error("readdatavalid raised without a read");

    a_valid_known: assert property (
        @(posedge uoe_csr_avmm) disable iff (rst_local) !$isunknown(readdatavalid)
    ) else $error("readdatavalid is unknown");

    a_rst_low_after_reset: assert property (
        @(posedge uoe_csr_avmm) $fell(rst_local) |-> (tx_rst == '0) && (rx_rst == '0)
    ) else $error("Channel resets not low after reset");

endmodule : udp_oe_csr_asserts

// Top level sees both the read strobe and the reset outputs
bind udp_oe_csr_top udp_oe_csr_asserts #(.NUM_CHAN(NUM_CHAN)) u_asserts (
    .uoe_csr_avmm  (uoe_csr_avmm),
    .rst_local     (rst_local),
    .read          (read),
    .readdatavalid (readdatavalid),
    .tx_rst        (tx_rst),
    .rx_rst        (rx_rst)
);

`default_nettype wire

// File: hdl/chan_addr_decode.sv
//////////////////////////////////////////////////
// Channel window decode into hit, index and
// register offset
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module chan_addr_decode
    import udp_oe_csr_pkg::*;
#(
    parameter  int NUM_CHAN   = 4,
    localparam int CHAN_IDX_W = chan_idx_width(NUM_CHAN)
) (
    input  word_addr_t            word_addr,
    output logic                  chan_hit,
    output logic [CHAN_IDX_W-1:0] chan_idx,
    output chan_reg_t             chan_reg
);

    localparam int REG_OFS_W = $clog2(CSR_ADDR_PER_CHANNEL);

    // First word past the last channel block
    localparam word_addr_t CHAN_END_ADDR =
        word_addr_t'(int'(CHAN_BASE_ADDR) + NUM_CHAN * CSR_ADDR_PER_CHANNEL);

    word_addr_t chan_ofs;  // Word offset from the window base

    assign chan_ofs = word_addr - CHAN_BASE_ADDR;

    assign chan_hit = (word_addr >= CHAN_BASE_ADDR) && (word_addr < CHAN_END_ADDR);

    // Blocks are a power of two long, index sits right above the offset
    assign chan_reg = chan_reg_t'(chan_ofs[REG_OFS_W-1:0]);
    assign chan_idx = chan_ofs[REG_OFS_W +: CHAN_IDX_W];

endmodule : chan_addr_decode

`default_nettype wire

// File: hdl/chan_ctrl_regs.sv
//////////////////////////////////////////////////
// Per-channel reset bits, shared misc control and
// per-channel read selection
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module chan_ctrl_regs
    import udp_oe_csr_pkg::*;
#(
    parameter  int NUM_CHAN   = 4,
    localparam int CHAN_IDX_W = chan_idx_width(NUM_CHAN)
) (
    input  logic                  uoe_csr_avmm,
    input  logic                  rst_local,
    input  logic                  write,
    input  logic                  chan_hit,
    input  logic [CHAN_IDX_W-1:0] chan_idx,
    input  chan_reg_t             chan_reg,
    input  csr_word_t             writedata,
    input  chan_sts_t             tx_status [NUM_CHAN],
    input  chan_sts_t             rx_status [NUM_CHAN],

    output logic [NUM_CHAN-1:0]   tx_rst,
    output logic [NUM_CHAN-1:0]   rx_rst,
    output csr_word_t             misc_ctrl,
    output csr_word_t             chan_rd_data
);

    csr_word_t chan_word [NUM_CHAN];  // Addressed word of each channel

    // chan_hit keeps chan_idx inside 0 to NUM_CHAN-1
    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            tx_rst    <= '0;
            rx_rst    <= '0;
            misc_ctrl <= '0;
        end else if (write && chan_hit) begin
            if (chan_reg == CHAN_RESET_OFS) begin
                tx_rst[chan_idx] <= writedata[1];
                rx_rst[chan_idx] <= writedata[0];
            end
            if (chan_reg == CHAN_MISC_CTRL_OFS) begin
                misc_ctrl <= writedata;  // One word shared by all channels
            end
        end
    end

    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        always_comb begin
            case (chan_reg)
                CHAN_INFO_OFS:      chan_word[c] = {48'h0, 8'(c), CHAN_INFO_TAG};
                CHAN_RESET_OFS:     chan_word[c] = {62'h0, tx_rst[c], rx_rst[c]};
                CHAN_STATUS_OFS:    chan_word[c] = {tx_status[c], rx_status[c]};
                CHAN_MISC_CTRL_OFS: chan_word[c] = misc_ctrl;
                default:            chan_word[c] = '0;
            endcase
        end
    end

    // Compare instead of index, chan_idx may point past NUM_CHAN
    always_comb begin
        chan_rd_data = '0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (chan_idx == CHAN_IDX_W'(c)) begin
                chan_rd_data = chan_word[c];
            end
        end
    end

endmodule : chan_ctrl_regs

`default_nettype wire

// File: hdl/csr_read_resp.sv
//////////////////////////////////////////////////
// Read source priority, bad address pattern and
// the registered read response
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csr_read_resp
    import udp_oe_csr_pkg::*;
(
    input  logic      uoe_csr_avmm,
    input  logic      rst_local,
    input  logic      read,
    input  logic      chan_hit,
    input  csr_word_t chan_rd_data,
    input  logic      shared_hit,
    input  csr_word_t shared_rd_data,

    output csr_word_t readdata,
    output logic      readdatavalid
);

    csr_word_t rd_sel;

    // Channel window first, then shared words, else the bad address pattern
    always_comb begin
        if (chan_hit) begin
            rd_sel = chan_rd_data;
        end else if (shared_hit) begin
            rd_sel = shared_rd_data;
        end else begin
            rd_sel = REG_RD_BADADDR_DATA;
        end
    end

    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            readdata      <= '0;
            readdatavalid <= 1'b0;
        end else begin
            readdatavalid <= read;     // One strobe per request, no stall
            if (read) begin
                readdata <= rd_sel;    // Held between reads
            end
        end
    end

endmodule : csr_read_resp

`default_nettype wire

// File: hdl/shared_csr_regs.sv
//////////////////////////////////////////////////
// Feature header, scratchpad, channel count and
// network settings with their read selection
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shared_csr_regs
    import udp_oe_csr_pkg::*;
#(
    parameter int NUM_CHAN = 4
) (
    input  logic       uoe_csr_avmm,
    input  logic       rst_local,
    input  logic       write,
    input  word_addr_t word_addr,
    input  csr_word_t  writedata,

    output csr_word_t  shared_rd_data,
    output logic       shared_hit,

    output mac_adr_t   fpga_mac_adr,
    output mac_adr_t   host_mac_adr,
    output ip_adr_t    fpga_ip_adr,
    output ip_adr_t    host_ip_adr,
    output ip_adr_t    fpga_netmask,
    output udp_port_t  fpga_udp_port,
    output udp_port_t  host_udp_port,
    output udp_port_t  payload_per_packet,
    output udp_port_t  checksum_ip
);

    csr_word_t scratchpad;

    // Each field keeps only the low bits of the write data
    always_ff @(posedge uoe_csr_avmm) begin
        if (rst_local) begin
            scratchpad         <= '0;
            fpga_mac_adr       <= '0;
            host_mac_adr       <= '0;
            fpga_ip_adr        <= '0;
            host_ip_adr        <= '0;
            fpga_netmask       <= '0;
            fpga_udp_port      <= '0;
            host_udp_port      <= '0;
            payload_per_packet <= DEFAULT_PAYLOAD_PER_PACKET;
            checksum_ip        <= '0;
        end else if (write) begin
            case (word_addr)
                SCRATCHPAD_ADDR:         scratchpad         <= writedata;
                FPGA_MAC_ADDR:           fpga_mac_adr       <= writedata[47:0];
                FPGA_IP_ADDR:            fpga_ip_adr        <= writedata[31:0];
                FPGA_UDP_PORT_ADDR:      fpga_udp_port      <= writedata[15:0];
                FPGA_NETMASK_ADDR:       fpga_netmask       <= writedata[31:0];
                HOST_MAC_ADDR:           host_mac_adr       <= writedata[47:0];
                HOST_IP_ADDR:            host_ip_adr        <= writedata[31:0];
                HOST_UDP_PORT_ADDR:      host_udp_port      <= writedata[15:0];
                PAYLOAD_PER_PACKET_ADDR: payload_per_packet <= writedata[15:0];
                CHECKSUM_IP_ADDR:        checksum_ip        <= writedata[15:0];
                default: ;  // Header words and channel count are read only
            endcase
        end
    end

    // Read selection for words 0 to 15
    always_comb begin
        shared_hit     = 1'b1;
        shared_rd_data = '0;
        case (word_addr)
            DFH_HEADER_ADDR:          shared_rd_data = DFH_HEADER;
            DFH_ID_LO_ADDR:           shared_rd_data = DFH_ID_LO;
            DFH_ID_HI_ADDR:           shared_rd_data = DFH_ID_HI;
            DFH_REG_ADDR_OFFSET_ADDR: shared_rd_data = DFH_REG_ADDR_OFFSET;
            DFH_REGSZ_ADDR:           shared_rd_data = DFH_REGSZ;
            SCRATCHPAD_ADDR:          shared_rd_data = scratchpad;
            NUM_CHANNELS_ADDR:        shared_rd_data = csr_word_t'(NUM_CHAN);

            FPGA_MAC_ADDR:            shared_rd_data = {16'h0, fpga_mac_adr};
            FPGA_IP_ADDR:             shared_rd_data = {32'h0, fpga_ip_adr};
            FPGA_UDP_PORT_ADDR:       shared_rd_data = {48'h0, fpga_udp_port};
            FPGA_NETMASK_ADDR:        shared_rd_data = {32'h0, fpga_netmask};
            HOST_MAC_ADDR:            shared_rd_data = {16'h0, host_mac_adr};
            HOST_IP_ADDR:             shared_rd_data = {32'h0, host_ip_adr};
            HOST_UDP_PORT_ADDR:       shared_rd_data = {48'h0, host_udp_port};
            PAYLOAD_PER_PACKET_ADDR:  shared_rd_data = {48'h0, payload_per_packet};
            CHECKSUM_IP_ADDR:         shared_rd_data = {48'h0, checksum_ip};

            default: begin
                shared_hit = 1'b0;  // Channel window or unmapped
            end
        endcase
    end

endmodule : shared_csr_regs

`default_nettype wire

// File: hdl/udp_oe_csr_pkg.sv
//////////////////////////////////////////////////
// Word and field types, register map and feature
// header constants of the UDP offload CSR block
//////////////////////////////////////////////////
`default_nettype none

package udp_oe_csr_pkg;

    typedef logic [63:0] csr_word_t;
    typedef logic [47:0] mac_adr_t;
    typedef logic [31:0] ip_adr_t;     // Also the netmask
    typedef logic [15:0] udp_port_t;   // Also payload size and checksum
    typedef logic [9:0]  word_addr_t;  // Byte address / 8
    typedef logic [2:0]  chan_reg_t;
    typedef logic [31:0] chan_sts_t;

    localparam int CSR_ADDR_PER_CHANNEL = 8;

    // Width of a channel index, at least one bit
    function automatic int chan_idx_width(input int num_chan);
        return (num_chan > 1) ? $clog2(num_chan) : 1;
    endfunction

    // Shared register map
    localparam word_addr_t DFH_HEADER_ADDR          = 10'd0;
    localparam word_addr_t DFH_ID_LO_ADDR           = 10'd1;
    localparam word_addr_t DFH_ID_HI_ADDR           = 10'd2;
    localparam word_addr_t DFH_REG_ADDR_OFFSET_ADDR = 10'd3;
    localparam word_addr_t DFH_REGSZ_ADDR           = 10'd4;
    localparam word_addr_t SCRATCHPAD_ADDR          = 10'd5;
    localparam word_addr_t NUM_CHANNELS_ADDR        = 10'd6;
    localparam word_addr_t FPGA_MAC_ADDR            = 10'd7;
    localparam word_addr_t FPGA_IP_ADDR             = 10'd8;
    localparam word_addr_t FPGA_UDP_PORT_ADDR       = 10'd9;
    localparam word_addr_t FPGA_NETMASK_ADDR        = 10'd10;
    localparam word_addr_t HOST_MAC_ADDR            = 10'd11;
    localparam word_addr_t HOST_IP_ADDR             = 10'd12;
    localparam word_addr_t HOST_UDP_PORT_ADDR       = 10'd13;
    localparam word_addr_t PAYLOAD_PER_PACKET_ADDR  = 10'd14;
    localparam word_addr_t CHECKSUM_IP_ADDR         = 10'd15;
    localparam word_addr_t CHAN_BASE_ADDR           = 10'd32;  // Channel 0 block

    // Offsets inside one channel block, 4 to 7 read zero
    localparam chan_reg_t CHAN_INFO_OFS      = 3'd0;
    localparam chan_reg_t CHAN_RESET_OFS     = 3'd1;
    localparam chan_reg_t CHAN_STATUS_OFS    = 3'd2;
    localparam chan_reg_t CHAN_MISC_CTRL_OFS = 3'd3;

    // DFHv1 header fields
    localparam logic [3:0]  DFH_FTYPE    = 4'h1;     // AFU
    localparam logic [7:0]  DFH_VER      = 8'h01;
    localparam logic [10:0] DFH_RSVD     = 11'h0;
    localparam logic        DFH_EOL      = 1'b1;     // Last feature in the list
    localparam logic [23:0] DFH_NEXT     = 24'h0;
    localparam logic [3:0]  DFH_FEAT_REV = 4'h0;
    localparam logic [11:0] DFH_FEAT_ID  = 12'h0AB;

    localparam logic [62:0] DFH_CSR_OFFSET = 63'h28;  // Scratchpad byte offset
    localparam logic        DFH_CSR_REL    = 1'b0;    // Relative to the header
    localparam logic [31:0] DFH_CSR_SIZE   = 32'h500; // Room for 16 channels
    localparam logic        DFH_HAS_PARAMS = 1'b0;
    localparam logic [14:0] DFH_GROUP      = 15'h0;
    localparam logic [15:0] DFH_INSTANCE   = 16'h0;

    // Works out to 64'h1010_0100_0000_00AB
    localparam csr_word_t DFH_HEADER = {DFH_FTYPE, DFH_VER, DFH_RSVD, DFH_EOL,
                                        DFH_NEXT, DFH_FEAT_REV, DFH_FEAT_ID};
    localparam csr_word_t DFH_ID_LO  = 64'h9A1F_2C6D_4B07_E315;  // GUID low half
    localparam csr_word_t DFH_ID_HI  = 64'h5E84_B0C2_71D9_4F36;
    localparam csr_word_t DFH_REG_ADDR_OFFSET = {DFH_CSR_OFFSET, DFH_CSR_REL};
    localparam csr_word_t DFH_REGSZ  = {DFH_CSR_SIZE, DFH_HAS_PARAMS, DFH_GROUP,
                                        DFH_INSTANCE};

    localparam udp_port_t  DEFAULT_PAYLOAD_PER_PACKET = 16'd1024;
    localparam csr_word_t  REG_RD_BADADDR_DATA        = 64'h0BAD_0BAD_0BAD_0BAD;
    localparam logic [7:0] CHAN_INFO_TAG              = 8'h10;

endpackage : udp_oe_csr_pkg

`default_nettype wire

// File: hdl/udp_oe_csr_top.sv
//////////////////////////////////////////////////
// UDP offload engine CSR block top level
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module udp_oe_csr_top
    import udp_oe_csr_pkg::*;
#(
    parameter  int NUM_CHAN   = 4,   // 1 to 16
    localparam int CHAN_IDX_W = chan_idx_width(NUM_CHAN)
) (
    input  logic                uoe_csr_avmm,
    input  logic                rst_local,

    // Host bus, byte addressed
    input  logic [12:0]         address,
    input  logic                read,
    input  logic                write,
    input  csr_word_t           writedata,
    output csr_word_t           readdata,
    output logic                readdatavalid,

    // Channel side
    input  chan_sts_t           tx_status [NUM_CHAN],
    input  chan_sts_t           rx_status [NUM_CHAN],
    output logic [NUM_CHAN-1:0] tx_rst,
    output logic [NUM_CHAN-1:0] rx_rst,
    output csr_word_t           misc_ctrl,

    // Network settings
    output mac_adr_t            fpga_mac_adr,
    output mac_adr_t            host_mac_adr,
    output ip_adr_t             fpga_ip_adr,
    output ip_adr_t             host_ip_adr,
    output ip_adr_t             fpga_netmask,
    output udp_port_t           fpga_udp_port,
    output udp_port_t           host_udp_port,
    output udp_port_t           payload_per_packet,
    output udp_port_t           checksum_ip
);

    word_addr_t            word_addr;
    logic                  chan_hit;
    logic [CHAN_IDX_W-1:0] chan_idx;
    chan_reg_t             chan_reg;
    logic                  shared_hit;
    csr_word_t             shared_rd_data;
    csr_word_t             chan_rd_data;

    assign word_addr = address[12:3];  // Word accesses only

    chan_addr_decode #(.NUM_CHAN(NUM_CHAN)) u_decode (
        .word_addr (word_addr),
        .chan_hit  (chan_hit),
        .chan_idx  (chan_idx),
        .chan_reg  (chan_reg)
    );

    shared_csr_regs #(.NUM_CHAN(NUM_CHAN)) u_shared (
        .uoe_csr_avmm       (uoe_csr_avmm),
        .rst_local          (rst_local),
        .write              (write),
        .word_addr          (word_addr),
        .writedata          (writedata),
        .shared_rd_data     (shared_rd_data),
        .shared_hit         (shared_hit),
        .fpga_mac_adr       (fpga_mac_adr),
        .host_mac_adr       (host_mac_adr),
        .fpga_ip_adr        (fpga_ip_adr),
        .host_ip_adr        (host_ip_adr),
        .fpga_netmask       (fpga_netmask),
        .fpga_udp_port      (fpga_udp_port),
        .host_udp_port      (host_udp_port),
        .payload_per_packet (payload_per_packet),
        .checksum_ip        (checksum_ip)
    );

    chan_ctrl_regs #(.NUM_CHAN(NUM_CHAN)) u_chan (
        .uoe_csr_avmm (uoe_csr_avmm),
        .rst_local    (rst_local),
        .write        (write),
        .chan_hit     (chan_hit),
        .chan_idx     (chan_idx),
        .chan_reg     (chan_reg),
        .writedata    (writedata),
        .tx_status    (tx_status),
        .rx_status    (rx_status),
        .tx_rst       (tx_rst),
        .rx_rst       (rx_rst),
        .misc_ctrl    (misc_ctrl),
        .chan_rd_data (chan_rd_data)
    );

    csr_read_resp u_resp (
        .uoe_csr_avmm   (uoe_csr_avmm),
        .rst_local      (rst_local),
        .read           (read),
        .chan_hit       (chan_hit),
        .chan_rd_data   (chan_rd_data),
        .shared_hit     (shared_hit),
        .shared_rd_data (shared_rd_data),
        .readdata       (readdata),
        .readdatavalid  (readdatavalid)
    );

endmodule : udp_oe_csr_top

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the CSR testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_udp_oe_csr

./obj_dir/Vtb_udp_oe_csr > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
    echo "Simulation run passed"
    exit 0
fi
echo "Simulation run failed"
exit 1
